// ==== hw/assoc_pkg.sv ====
package assoc_pkg;

    //////////////////////////////////////////////////////////////////////
    // Widths and sizes
    //////////////////////////////////////////////////////////////////////

    // Handles, indices, values, bounds, codes and ranks share one width
    localparam int DATA_W      = 8;
    localparam int NUM_CELLS   = 8;
    localparam int GROUP_CELLS = 4;
    localparam int HIT_CNT_W   = 4;

    //////////////////////////////////////////////////////////////////////
    // Cell commands
    //////////////////////////////////////////////////////////////////////

    typedef enum logic [2:0] {
        OP_UPDATE     = 3'd0,
        OP_LOOKUP     = 3'd1,
        OP_ENCODE     = 3'd2,
        OP_SHIFT_UP   = 3'd3,
        OP_SHIFT_DOWN = 3'd4,
        OP_FIND_FREE  = 3'd5,
        OP_RANK       = 3'd6,
        OP_RANGE      = 3'd7
    } cell_op_e;

    //////////////////////////////////////////////////////////////////////
    // APB register map
    //////////////////////////////////////////////////////////////////////

    localparam logic [11:0] REG_INDEX  = 12'h000;
    localparam logic [11:0] REG_VALUE  = 12'h004;
    localparam logic [11:0] REG_META   = 12'h008;
    // Opcode in 2:0, is_meta in 8
    localparam logic [11:0] REG_CMD    = 12'h00C;
    // Busy in 0, hit in 1, hit count in 11:8
    localparam logic [11:0] REG_STATUS = 12'h010;
    // Value in 7:0, context in 15:8, handle in 23:16
    localparam logic [11:0] REG_RESULT = 12'h014;

endpackage

// ==== hw/assoc_cell.sv ====
`timescale 1ns/10ps

module assoc_cell #(
    parameter int CELL_HANDLE = 0
) (
    input  logic                        clk,
    input  logic                        rst,
    input  logic                        op_valid,
    input  assoc_pkg::cell_op_e         op,
    input  logic                        is_meta,
    input  logic [assoc_pkg::DATA_W-1:0] index,
    input  logic [assoc_pkg::DATA_W-1:0] value,
    input  logic [assoc_pkg::DATA_W-1:0] meta,
    output logic                        hit,
    output logic [assoc_pkg::DATA_W-1:0] res_value,
    output logic [assoc_pkg::DATA_W-1:0] res_context
);

    import assoc_pkg::*;

    localparam logic [DATA_W-1:0] HANDLE = DATA_W'(CELL_HANDLE);

    // Element record
    logic              arr_def_q;
    logic              elt_def_q;
    logic [DATA_W-1:0] code_q;
    logic [DATA_W-1:0] rank_q;
    logic [DATA_W-1:0] low_q;
    logic [DATA_W-1:0] high_q;
    logic [DATA_W-1:0] elt_index_q;
    logic [DATA_W-1:0] elt_value_q;

    logic              arr_def_d;
    logic              elt_def_d;
    logic [DATA_W-1:0] code_d;
    logic [DATA_W-1:0] rank_d;
    logic [DATA_W-1:0] low_d;
    logic [DATA_W-1:0] high_d;
    logic [DATA_W-1:0] elt_index_d;
    logic [DATA_W-1:0] elt_value_d;

    logic              hit_d;
    logic [DATA_W-1:0] value_d;
    logic [DATA_W-1:0] context_d;

    //////////////////////////////////////////////////////////////////////
    // Command evaluation
    //////////////////////////////////////////////////////////////////////

    always_comb begin
        arr_def_d   = arr_def_q;
        elt_def_d   = elt_def_q;
        code_d      = code_q;
        rank_d      = rank_q;
        low_d       = low_q;
        high_d      = high_q;
        elt_index_d = elt_index_q;
        elt_value_d = elt_value_q;
        hit_d       = 1'b0;
        value_d     = '0;
        context_d   = '0;

        case (op)
            OP_UPDATE: begin
                hit_d = is_meta && (meta == HANDLE);
                if (hit_d) begin
                    arr_def_d   = 1'b1;
                    elt_def_d   = 1'b1;
                    code_d      = HANDLE;
                    low_d       = HANDLE;
                    high_d      = HANDLE;
                    elt_index_d = index;
                    elt_value_d = value;
                    rank_d      = DATA_W'(1);
                end
                value_d   = HANDLE;
                context_d = HANDLE;
            end
            OP_LOOKUP: begin
                hit_d = is_meta && (elt_index_q == index) &&
                        (meta >= low_q) && (meta <= high_q);
                value_d   = elt_value_q;
                context_d = rank_q;
            end
            OP_ENCODE: begin
                hit_d     = is_meta && arr_def_q && (meta == HANDLE);
                value_d   = code_q;
                context_d = code_q;
            end
            OP_RANK: begin
                hit_d     = is_meta && arr_def_q && (meta == HANDLE);
                value_d   = rank_q;
                context_d = rank_q;
            end
            OP_RANGE: begin
                hit_d     = elt_def_q && (meta == HANDLE);
                value_d   = is_meta ? high_q : low_q;
                context_d = is_meta ? high_q : low_q;
            end
            OP_FIND_FREE: begin
                hit_d     = !elt_def_q;
                value_d   = HANDLE;
                context_d = HANDLE;
            end
            OP_SHIFT_UP: begin
                if (is_meta) begin
                    if (index == HANDLE) begin
                        code_d = meta + 1'b1;
                        low_d  = meta + 1'b1;
                        high_d = meta + 1'b1;
                        rank_d = value + 1'b1;
                    end else begin
                        if (arr_def_q && code_q > meta) begin
                            code_d = code_q + 1'b1;
                        end
                        if (elt_def_q && low_q > meta) begin
                            low_d = low_q + 1'b1;
                        end
                        if (elt_def_q && high_q >= meta) begin
                            high_d = high_q + 1'b1;
                        end
                    end
                end
            end
            OP_SHIFT_DOWN: begin
                // Removal of the element owned by this handle
                if (is_meta && index == HANDLE) begin
                    arr_def_d = 1'b0;
                    rank_d    = '0;
                    if (elt_def_q && meta < low_q) begin
                        low_d  = low_q - 1'b1;
                        high_d = high_q - 1'b1;
                    end else if (elt_def_q && meta >= low_q && meta <= high_q) begin
                        high_d = high_q - 1'b1;
                    end
                    if (elt_def_q && low_d > high_d) begin
                        elt_def_d = 1'b0;
                        arr_def_d = 1'b0;
                    end
                end
                // Codes above the removed one close the gap
                if (is_meta && arr_def_q && code_q > meta) begin
                    code_d = code_q - 1'b1;
                end
            end
            default: begin
            end
        endcase
    end

    always_ff @(posedge clk) begin
        if (rst) begin
            arr_def_q   <= 1'b0;
            elt_def_q   <= 1'b0;
            code_q      <= '0;
            rank_q      <= '0;
            low_q       <= '0;
            high_q      <= '0;
            elt_index_q <= '0;
            elt_value_q <= '0;
            hit         <= 1'b0;
            res_value   <= '0;
            res_context <= '0;
        end else if (op_valid) begin
            arr_def_q   <= arr_def_d;
            elt_def_q   <= elt_def_d;
            code_q      <= code_d;
            rank_q      <= rank_d;
            low_q       <= low_d;
            high_q      <= high_d;
            elt_index_q <= elt_index_d;
            elt_value_q <= elt_value_d;
            hit         <= hit_d;
            res_value   <= value_d;
            res_context <= context_d;
        end
    end

    // Bounds stay ordered across every command sequence
    a_bounds_ordered: assert property (@(posedge clk) disable iff (rst)
        elt_def_q |-> (low_q <= high_q));

    // Shifts only renumber, they never report a match
    a_shift_no_hit: assert property (@(posedge clk) disable iff (rst)
        (op_valid && (op == OP_SHIFT_UP || op == OP_SHIFT_DOWN)) |=> !hit);

endmodule

// ==== hw/cell_group.sv ====
`timescale 1ns/10ps

module cell_group #(
    parameter int BASE_HANDLE = 0
) (
    input  logic                                              clk,
    input  logic                                              rst,
    input  logic                                              op_valid,
    input  assoc_pkg::cell_op_e                               op,
    input  logic                                              is_meta,
    input  logic [assoc_pkg::DATA_W-1:0]                      index,
    input  logic [assoc_pkg::DATA_W-1:0]                      value,
    input  logic [assoc_pkg::DATA_W-1:0]                      meta,
    output logic [assoc_pkg::GROUP_CELLS-1:0]                 hits,
    output logic [assoc_pkg::GROUP_CELLS*assoc_pkg::DATA_W-1:0] values,
    output logic [assoc_pkg::GROUP_CELLS*assoc_pkg::DATA_W-1:0] contexts,
    output logic                                              grp_valid
);

    import assoc_pkg::*;

    // Cell g of the group owns handle BASE_HANDLE + g
    for (genvar g = 0; g < GROUP_CELLS; g++) begin : g_cell
        assoc_cell #(
            .CELL_HANDLE (BASE_HANDLE + g)
        ) u_cell (
            .clk         (clk),
            .rst         (rst),
            .op_valid    (op_valid),
            .op          (op),
            .is_meta     (is_meta),
            .index       (index),
            .value       (value),
            .meta        (meta),
            .hit         (hits[g]),
            .res_value   (values[g*DATA_W +: DATA_W]),
            .res_context (contexts[g*DATA_W +: DATA_W])
        );
    end

    // Valid lines up with the registered cell outputs
    always_ff @(posedge clk) begin
        if (rst) begin
            grp_valid <= 1'b0;
        end else begin
            grp_valid <= op_valid;
        end
    end

endmodule

// ==== hw/match_combine.sv ====
`timescale 1ns/10ps

module match_combine (
    input  logic                                                clk,
    input  logic                                                rst,
    input  logic [assoc_pkg::GROUP_CELLS-1:0]                   lo_hits,
    input  logic [assoc_pkg::GROUP_CELLS*assoc_pkg::DATA_W-1:0] lo_values,
    input  logic [assoc_pkg::GROUP_CELLS*assoc_pkg::DATA_W-1:0] lo_contexts,
    input  logic                                                lo_valid,
    input  logic [assoc_pkg::GROUP_CELLS-1:0]                   hi_hits,
    input  logic [assoc_pkg::GROUP_CELLS*assoc_pkg::DATA_W-1:0] hi_values,
    input  logic [assoc_pkg::GROUP_CELLS*assoc_pkg::DATA_W-1:0] hi_contexts,
    input  logic                                                hi_valid,
    output logic                                                res_valid,
    output logic                                                res_hit,
    output logic [assoc_pkg::DATA_W-1:0]                        res_handle,
    output logic [assoc_pkg::DATA_W-1:0]                        res_value,
    output logic [assoc_pkg::DATA_W-1:0]                        res_context,
    output logic [assoc_pkg::HIT_CNT_W-1:0]                     res_count
);

    import assoc_pkg::*;

    // Low group in the low slots, so index equals handle
    logic [NUM_CELLS-1:0]        all_hits;
    logic [NUM_CELLS*DATA_W-1:0] all_values;
    logic [NUM_CELLS*DATA_W-1:0] all_contexts;

    logic              win_hit;
    logic [DATA_W-1:0] win_handle;
    logic [DATA_W-1:0] win_value;
    logic [DATA_W-1:0] win_context;
    logic [HIT_CNT_W-1:0] hit_count;

    assign all_hits     = {hi_hits, lo_hits};
    assign all_values   = {hi_values, lo_values};
    assign all_contexts = {hi_contexts, lo_contexts};

    // Scan downward so the lowest hitting handle is the last one kept
    always_comb begin
        win_hit     = 1'b0;
        win_handle  = '0;
        win_value   = '0;
        win_context = '0;
        hit_count   = '0;
        for (int i = NUM_CELLS - 1; i >= 0; i--) begin
            hit_count = hit_count + HIT_CNT_W'(all_hits[i]);
            if (all_hits[i]) begin
                win_hit     = 1'b1;
                win_handle  = DATA_W'(i);
                win_value   = all_values[i*DATA_W +: DATA_W];
                win_context = all_contexts[i*DATA_W +: DATA_W];
            end
        end
    end

    always_ff @(posedge clk) begin
        if (rst) begin
            res_valid   <= 1'b0;
            res_hit     <= 1'b0;
            res_handle  <= '0;
            res_value   <= '0;
            res_context <= '0;
            res_count   <= '0;
        end else begin
            res_valid <= lo_valid && hi_valid;
            if (lo_valid && hi_valid) begin
                res_hit     <= win_hit;
                res_handle  <= win_handle;
                res_value   <= win_value;
                res_context <= win_context;
                res_count   <= hit_count;
            end
        end
    end

    // Both groups see the same broadcast
    a_groups_aligned: assert property (@(posedge clk) disable iff (rst)
        lo_valid == hi_valid);

endmodule

// ==== hw/apb_cmd_port.sv ====
`timescale 1ns/10ps

module apb_cmd_port (
    input  logic                           clk,
    input  logic                           rst,
    input  logic                           psel,
    input  logic                           penable,
    input  logic                           pwrite,
    input  logic [11:0]                    paddr,
    input  logic [31:0]                    pwdata,
    output logic [31:0]                    prdata,
    output logic                           pready,
    output logic                           pslverr,
    output logic                           op_valid,
    output assoc_pkg::cell_op_e            op,
    output logic                           is_meta,
    output logic [assoc_pkg::DATA_W-1:0]   index,
    output logic [assoc_pkg::DATA_W-1:0]   value,
    output logic [assoc_pkg::DATA_W-1:0]   meta,
    input  logic                           res_valid,
    input  logic                           res_hit,
    input  logic [assoc_pkg::DATA_W-1:0]   res_handle,
    input  logic [assoc_pkg::DATA_W-1:0]   res_value,
    input  logic [assoc_pkg::DATA_W-1:0]   res_context,
    input  logic [assoc_pkg::HIT_CNT_W-1:0] res_count
);

    import assoc_pkg::*;

    logic                 access;
    logic                 mapped;
    logic                 launch;
    logic                 busy;
    logic                 stat_hit;
    logic [HIT_CNT_W-1:0] stat_count;
    logic [DATA_W-1:0]    result_handle;
    logic [DATA_W-1:0]    result_value;
    logic [DATA_W-1:0]    result_context;

    assign access = psel && penable;
    assign mapped = (paddr == REG_INDEX) || (paddr == REG_VALUE) || (paddr == REG_META) ||
                    (paddr == REG_CMD) || (paddr == REG_STATUS) || (paddr == REG_RESULT);
    assign launch = access && pwrite && (paddr == REG_CMD) && !busy;

    // No wait states
    assign pready  = 1'b1;
    assign pslverr = access && (!mapped || (pwrite && (paddr == REG_CMD) && busy));

    //////////////////////////////////////////////////////////////////////
    // Register writes and command launch
    //////////////////////////////////////////////////////////////////////

    always_ff @(posedge clk) begin
        if (rst) begin
            index          <= '0;
            value          <= '0;
            meta           <= '0;
            op             <= OP_UPDATE;
            is_meta        <= 1'b0;
            op_valid       <= 1'b0;
            busy           <= 1'b0;
            stat_hit       <= 1'b0;
            stat_count     <= '0;
            result_handle  <= '0;
            result_value   <= '0;
            result_context <= '0;
        end else begin
            op_valid <= launch;
            if (access && pwrite && paddr == REG_INDEX) begin
                index <= pwdata[DATA_W-1:0];
            end
            if (access && pwrite && paddr == REG_VALUE) begin
                value <= pwdata[DATA_W-1:0];
            end
            if (access && pwrite && paddr == REG_META) begin
                meta <= pwdata[DATA_W-1:0];
            end
            if (launch) begin
                op      <= cell_op_e'(pwdata[2:0]);
                is_meta <= pwdata[8];
                busy    <= 1'b1;
            end else if (res_valid) begin
                busy           <= 1'b0;
                stat_hit       <= res_hit;
                stat_count     <= res_count;
                result_handle  <= res_handle;
                result_value   <= res_value;
                result_context <= res_context;
            end
        end
    end

    // Read mux
    always_comb begin
        prdata = '0;
        case (paddr)
            REG_INDEX:  prdata[DATA_W-1:0] = index;
            REG_VALUE:  prdata[DATA_W-1:0] = value;
            REG_META:   prdata[DATA_W-1:0] = meta;
            REG_CMD:    prdata = {23'd0, is_meta, 5'd0, op};
            REG_STATUS: prdata = {20'd0, stat_count, 6'd0, stat_hit, busy};
            REG_RESULT: prdata = {8'd0, result_handle, result_context, result_value};
            default:    prdata = '0;
        endcase
    end

    // One command in flight at a time
    a_no_launch_when_busy: assert property (@(posedge clk) disable iff (rst)
        $rose(op_valid) |-> !$past(busy));

endmodule

// ==== hw/assoc_mem_top.sv ====
`timescale 1ns/10ps

module assoc_mem_top (
    input  logic        clk,
    input  logic        rst,
    input  logic        psel,
    input  logic        penable,
    input  logic        pwrite,
    input  logic [11:0] paddr,
    input  logic [31:0] pwdata,
    output logic [31:0] prdata,
    output logic        pready,
    output logic        pslverr
);

    import assoc_pkg::*;

    // Broadcast command
    logic              op_valid;
    cell_op_e          op;
    logic              is_meta;
    logic [DATA_W-1:0] index;
    logic [DATA_W-1:0] value;
    logic [DATA_W-1:0] meta;

    // Group outputs
    logic [GROUP_CELLS-1:0]        lo_hits;
    logic [GROUP_CELLS*DATA_W-1:0] lo_values;
    logic [GROUP_CELLS*DATA_W-1:0] lo_contexts;
    logic                          lo_valid;
    logic [GROUP_CELLS-1:0]        hi_hits;
    logic [GROUP_CELLS*DATA_W-1:0] hi_values;
    logic [GROUP_CELLS*DATA_W-1:0] hi_contexts;
    logic                          hi_valid;

    // Combined result
    logic                 res_valid;
    logic                 res_hit;
    logic [DATA_W-1:0]    res_handle;
    logic [DATA_W-1:0]    res_value;
    logic [DATA_W-1:0]    res_context;
    logic [HIT_CNT_W-1:0] res_count;

    apb_cmd_port u_apb (
        .clk         (clk),
        .rst         (rst),
        .psel        (psel),
        .penable     (penable),
        .pwrite      (pwrite),
        .paddr       (paddr),
        .pwdata      (pwdata),
        .prdata      (prdata),
        .pready      (pready),
        .pslverr     (pslverr),
        .op_valid    (op_valid),
        .op          (op),
        .is_meta     (is_meta),
        .index       (index),
        .value       (value),
        .meta        (meta),
        .res_valid   (res_valid),
        .res_hit     (res_hit),
        .res_handle  (res_handle),
        .res_value   (res_value),
        .res_context (res_context),
        .res_count   (res_count)
    );

    cell_group #(
        .BASE_HANDLE (0)
    ) u_grp_lo (
        .clk       (clk),
        .rst       (rst),
        .op_valid  (op_valid),
        .op        (op),
        .is_meta   (is_meta),
        .index     (index),
        .value     (value),
        .meta      (meta),
        .hits      (lo_hits),
        .values    (lo_values),
        .contexts  (lo_contexts),
        .grp_valid (lo_valid)
    );

    cell_group #(
        .BASE_HANDLE (GROUP_CELLS)
    ) u_grp_hi (
        .clk       (clk),
        .rst       (rst),
        .op_valid  (op_valid),
        .op        (op),
        .is_meta   (is_meta),
        .index     (index),
        .value     (value),
        .meta      (meta),
        .hits      (hi_hits),
        .values    (hi_values),
        .contexts  (hi_contexts),
        .grp_valid (hi_valid)
    );

    match_combine u_comb (
        .clk         (clk),
        .rst         (rst),
        .lo_hits     (lo_hits),
        .lo_values   (lo_values),
        .lo_contexts (lo_contexts),
        .lo_valid    (lo_valid),
        .hi_hits     (hi_hits),
        .hi_values   (hi_values),
        .hi_contexts (hi_contexts),
        .hi_valid    (hi_valid),
        .res_valid   (res_valid),
        .res_hit     (res_hit),
        .res_handle  (res_handle),
        .res_value   (res_value),
        .res_context (res_context),
        .res_count   (res_count)
    );

endmodule

// ==== dv/assoc_mem_tb.sv ====
`timescale 1ns/10ps

module assoc_mem_tb;

    import assoc_pkg::*;

    localparam string       GOLDEN_FILE    = "dv/assoc_golden.txt";
    localparam int          CLK_PERIOD     = 10;
    localparam int          RESET_CYCLES   = 8;
    localparam int          CYCLES_PER_CMD = 20;
    localparam int          TIMEOUT_MARGIN = 100;
    localparam int          NUM_FIELDS     = 10;
    localparam logic [11:0] UNMAPPED_ADDR  = 12'h018;

    logic        clk;
    logic        rst;
    logic        psel;
    logic        penable;
    logic        pwrite;
    logic [11:0] paddr;
    logic [31:0] pwdata;
    logic [31:0] prdata;
    logic        pready;
    logic        pslverr;

    // One golden line per entry, ten byte fields, first field in the top byte
    logic [NUM_FIELDS*8-1:0] vectors [$];

    int errors      = 0;
    int cycle_count = 0;
    int cycle_limit = 0;

    assoc_mem_top i_dut (
        .clk     (clk),
        .rst     (rst),
        .psel    (psel),
        .penable (penable),
        .pwrite  (pwrite),
        .paddr   (paddr),
        .pwdata  (pwdata),
        .prdata  (prdata),
        .pready  (pready),
        .pslverr (pslverr)
    );

    always #(CLK_PERIOD/2) clk = ~clk;

    always @(posedge clk) begin
        cycle_count = cycle_count + 1;
        if (cycle_limit > 0 && cycle_count >= cycle_limit) begin
            $display("Run timed out after %0d cycles with %0d errors", cycle_count, errors);
            $display("** FAIL **");
            $finish;
        end
    end

    //////////////////////////////////////////////////////////////////////
    // APB access, called on a falling edge and returning on one
    //////////////////////////////////////////////////////////////////////

    task automatic apb_write(input logic [11:0] addr, input logic [31:0] data,
                             output logic err);
        psel    = 1'b1;
        penable = 1'b0;
        pwrite  = 1'b1;
        paddr   = addr;
        pwdata  = data;
        @(negedge clk);
        penable = 1'b1;
        #(CLK_PERIOD/4);
        err = pslverr;
        check_field("pready", 32'd1, 32'(pready));
        @(negedge clk);
        psel    = 1'b0;
        penable = 1'b0;
        pwrite  = 1'b0;
    endtask

    task automatic apb_read(input logic [11:0] addr, output logic [31:0] data,
                            output logic err);
        psel    = 1'b1;
        penable = 1'b0;
        pwrite  = 1'b0;
        paddr   = addr;
        @(negedge clk);
        penable = 1'b1;
        #(CLK_PERIOD/4);
        data = prdata;
        err  = pslverr;
        check_field("pready", 32'd1, 32'(pready));
        @(negedge clk);
        psel    = 1'b0;
        penable = 1'b0;
    endtask

    task automatic check_field(input string name, input logic [31:0] expected,
                               input logic [31:0] actual);
        assert (actual == expected) else begin
            $display("MISMATCH at %0t: %s expected %0h, got %0h",
                     $time, name, expected, actual);
            errors++;
        end
    endtask

    function automatic logic [7:0] field_of(input logic [NUM_FIELDS*8-1:0] vec, input int k);
        return vec[NUM_FIELDS*8-1-8*k -: 8];
    endfunction

    function automatic logic [31:0] cmd_word(input logic [7:0] opcode, input logic [7:0] flag);
        return {23'd0, flag[0], 5'd0, opcode[2:0]};
    endfunction

    //////////////////////////////////////////////////////////////////////
    // One golden command
    //////////////////////////////////////////////////////////////////////

    task automatic run_vector(input logic [NUM_FIELDS*8-1:0] vec);
        logic        err;
        logic [31:0] status;
        logic [31:0] result;
        logic [7:0]  opcode;
        logic [7:0]  flag;

        opcode = field_of(vec, 0);
        flag   = field_of(vec, 1);
        apb_write(REG_INDEX, {24'd0, field_of(vec, 2)}, err);
        apb_write(REG_VALUE, {24'd0, field_of(vec, 3)}, err);
        apb_write(REG_META, {24'd0, field_of(vec, 4)}, err);
        apb_write(REG_CMD, cmd_word(opcode, flag), err);
        check_field("pslverr", 32'd0, 32'(err));

        // Second command while the first is in flight must bounce
        apb_write(REG_CMD, cmd_word(opcode + 8'd1, flag), err);
        check_field("pslverr", 32'd1, 32'(err));

        status = 32'd1;
        while (status[0]) begin
            apb_read(REG_STATUS, status, err);
        end
        check_field("hit", 32'(field_of(vec, 5)), 32'(status[1]));
        check_field("hit_count", 32'(field_of(vec, 9)), 32'(status[11:8]));

        apb_read(REG_RESULT, result, err);
        check_field("handle", 32'(field_of(vec, 6)), 32'(result[23:16]));
        check_field("value", 32'(field_of(vec, 7)), 32'(result[7:0]));
        check_field("context", 32'(field_of(vec, 8)), 32'(result[15:8]));
    endtask

    initial begin
        int                      fd;
        int                      got;
        int                      f [NUM_FIELDS];
        string                   line;
        logic [NUM_FIELDS*8-1:0] vec;
        logic                    err;
        logic [31:0]             rdata;

        clk     = 1'b0;
        rst     = 1'b1;
        psel    = 1'b0;
        penable = 1'b0;
        pwrite  = 1'b0;
        paddr   = '0;
        pwdata  = '0;

        // Lines that do not scan as ten hex fields are comments
        fd = $fopen(GOLDEN_FILE, "r");
        if (fd == 0) begin
            $display("Cannot open the golden file %s", GOLDEN_FILE);
            errors++;
        end else begin
            while (!$feof(fd)) begin
                if ($fgets(line, fd) > 0) begin
                    got = $sscanf(line, "%h %h %h %h %h %h %h %h %h %h", f[0], f[1], f[2],
                                  f[3], f[4], f[5], f[6], f[7], f[8], f[9]);
                    if (got == NUM_FIELDS) begin
                        for (int k = 0; k < NUM_FIELDS; k++) begin
                            vec[NUM_FIELDS*8-1-8*k -: 8] = f[k][7:0];
                        end
                        vectors.push_back(vec);
                    end
                end
            end
            $fclose(fd);
        end
        if (vectors.size() == 0) begin
            $display("No command lines were found in the golden file");
            errors++;
        end
        cycle_limit = vectors.size() * CYCLES_PER_CMD + TIMEOUT_MARGIN;

        repeat (RESET_CYCLES) @(posedge clk);
        @(negedge clk);
        rst = 1'b0;

        foreach (vectors[i]) begin
            run_vector(vectors[i]);
        end

        // Hole in the register map
        apb_read(UNMAPPED_ADDR, rdata, err);
        check_field("pslverr", 32'd1, 32'(err));
        check_field("prdata", 32'd0, rdata);

        $display("Commands run: %0d, errors: %0d", vectors.size(), errors);
        if (errors == 0) begin
            $display("** PASS **");
        end else begin
            $display("** FAIL **");
        end
        $finish;
    end

endmodule

// ==== dv/assoc_golden.txt ====
// opcode is_meta index value meta  exp_hit exp_handle exp_value exp_context exp_count
// opcodes 0 update 1 lookup 2 encode 3 shift_up 4 shift_down 5 find_free 6 rank 7 range
5 0 00 00 00  1 00 00 00 8
0 1 10 a5 03  1 03 03 03 1
5 0 00 00 00  1 00 00 00 7
0 1 20 5a 01  1 01 01 01 1
0 1 30 c3 02  1 02 02 02 1
0 1 10 77 06  1 06 06 06 1
1 1 10 00 03  1 03 a5 01 1
1 1 10 00 06  1 06 77 01 1
1 0 10 00 03  0 00 00 00 0
2 1 00 00 02  1 02 02 02 1
6 1 00 00 03  1 03 01 01 1
7 1 00 00 06  1 06 06 06 1
2 1 00 00 05  0 00 00 00 0
7 1 00 00 04  0 00 00 00 0
3 1 02 01 02  0 00 00 00 0
7 1 00 00 02  1 02 03 03 1
2 1 00 00 03  1 03 04 04 1
7 0 00 00 06  1 06 07 07 1
6 1 00 00 02  1 02 02 02 1
5 0 00 00 00  1 00 00 00 4
4 1 01 00 01  0 00 00 00 0
5 0 00 00 00  1 00 00 00 5
2 1 00 00 02  1 02 02 02 1
2 1 00 00 06  1 06 06 06 1
2 1 00 00 01  0 00 00 00 0

// ==== flist.f ====
hw/assoc_pkg.sv
hw/assoc_cell.sv
hw/cell_group.sv
hw/match_combine.sv
hw/apb_cmd_port.sv
hw/assoc_mem_top.sv
dv/assoc_mem_tb.sv

// ==== Makefile ====
# Verilator build and run of the associative array testbench

VERILATOR ?= verilator
TOP       ?= assoc_mem_tb
FLIST     ?= flist.f
BUILD_DIR ?= obj_dir
LOG       ?= sim.log
VFLAGS    ?= --binary --timing --assert -j 0

.PHONY: help test clean

help:
	@echo "Targets:"
	@echo "  test   build with Verilator, run the testbench, check the log"
	@echo "  clean  remove the build directory and the log"
	@echo "Variables: VERILATOR TOP FLIST BUILD_DIR LOG VFLAGS"

test:
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) -f $(FLIST) -Mdir $(BUILD_DIR)
	./$(BUILD_DIR)/V$(TOP) | tee $(LOG)
	@if grep -q '^\*\* PASS \*\*$$' $(LOG); then \
		echo "Simulation passed"; \
	else \
		echo "Simulation failed, see $(LOG)"; \
		exit 1; \
	fi

clean:
	rm -rf $(BUILD_DIR) $(LOG)
